// File: src/dpll_pkg.sv
// Shared types and constants of the frequency-locked loop controller.
// The loop trims a ring oscillator so that one period of the slow
// reference input spans a programmed number of fast clock cycles.
package dpll_pkg;

    // Phase length in clock cycles, saturating at 31
    // The target ratio div uses the same type
    typedef logic [4:0] count_t;

    // Sum of the two most recent phase lengths, one bit wider than a count
    typedef logic [5:0] period_sum_t;

    // Integer part of the trim value, from 0 to 31
    typedef logic [4:0] trim_level_t;

    // Width of one half of the thermometer code
    localparam int TRIM_GROUP_BITS = 13;

    // Thermometer code to the ring oscillator
    // Bits 12:0 form the first group and bits 25:13 the second group
    typedef logic [2*TRIM_GROUP_BITS-1:0] trim_code_t;

    // Order in which the bits of a group switch on as the level rises.
    // Neighbouring steps land far apart in the ring, so the added delay
    // is spread evenly along the stages instead of piling up at one end
    localparam int TRIM_FILL_ORDER [TRIM_GROUP_BITS] = '{
        0, 6, 10, 3, 8, 12, 5, 2, 9, 4, 11, 1, 7
    };

    // Result of one period measurement
    typedef struct packed {
        // High for one cycle when a comparison is due
        logic        sample;
        // Current phase count plus the previous one, valid with sample
        period_sum_t sum;
    } period_meas_t;

endpackage

// File: src/period_measure.sv
`timescale 1ns/1ps

// Measures the high and low phases of the reference input osc in cycles
// of the local clock, and raises a compare strobe on every osc edge once
// enough edges have been seen for the period sum to be meaningful
module period_measure (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  osc,
    output dpll_pkg::period_meas_t meas
);
    import dpll_pkg::*;

    // Stages 0 and 1 synchronize osc, stage 2 keeps the previous value
    logic [2:0] osc_sync;

    // Length of the phase in progress and of the phase before it
    count_t count_now;
    count_t count_last;

    // Warm-up register, one bit is shifted in per detected edge
    logic [2:0] fill;

    logic edge_seen;
    logic warm;

    // An edge shows up as a difference between the last two stages.
    // That is one cycle after the second clock edge following the
    // change on osc
    assign edge_seen = osc_sync[2] ^ osc_sync[1];

    // After reset the first counts start mid-phase and the first sums
    // are garbage, so comparisons wait until three edges have passed
    assign warm = &fill;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            osc_sync   <= '0;
            count_now  <= '0;
            count_last <= '0;
            fill       <= '0;
        end else begin
            osc_sync <= {osc_sync[1:0], osc};

            if (edge_seen) begin
                // Close the current phase and start counting the next.
                // The edge cycle already belongs to the new phase
                count_last <= count_now;
                count_now  <= count_t'(1);
                fill       <= {fill[1:0], 1'b1};
            end else if (count_now != '1) begin
                // Long phases stop at the top of the range
                count_now <= count_now + 1'b1;
            end
        end
    end

    // The strobe and the sum are taken straight from the registers so
    // the accumulator can act at the end of the edge cycle itself
    always_comb begin
        meas.sample = edge_seen & warm;
        meas.sum    = period_sum_t'(count_now) + period_sum_t'(count_last);
    end

endmodule

// File: src/trim_accumulator.sv
`timescale 1ns/1ps

// Integrates the frequency error into a saturating trim value.
// The value carries FRAC_BITS fractional bits below the integer level,
// which sets the loop gain: the level moves only after several steps
// in the same direction
module trim_accumulator #(
    parameter int FRAC_BITS = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dpll_pkg::period_meas_t meas,
    input  dpll_pkg::count_t       div,
    output dpll_pkg::trim_level_t  level
);
    import dpll_pkg::*;

    localparam int LEVEL_BITS = $bits(trim_level_t);
    localparam int TRIM_BITS  = LEVEL_BITS + FRAC_BITS;

    // Full trim value with the fraction in the low bits
    logic [TRIM_BITS-1:0] trim_value;

    // Target sum widened to the width of the measured sum
    period_sum_t target;

    assign target = period_sum_t'(div);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // Bit 0 of the code has to be clear for the ring to start,
            // so the loop starts from the fastest setting
            trim_value <= '0;
        end else if (meas.sample) begin
            if (meas.sum > target) begin
                // More cycles than wanted per period, clock too fast
                if (trim_value != '1) begin
                    trim_value <= trim_value + 1'b1;
                end
            end else if (meas.sum < target) begin
                // Fewer cycles than wanted, clock too slow
                if (trim_value != '0) begin
                    trim_value <= trim_value - 1'b1;
                end
            end
            // An exact match leaves the value alone
        end
    end

    // The fractional bits only filter, the oscillator sees the integer part
    assign level = trim_value[TRIM_BITS-1:FRAC_BITS];

endmodule

// File: src/trim_encoder.sv
`timescale 1ns/1ps

// Turns the integer trim level into the thermometer code for the ring
// oscillator. The first group fills up before the second one starts.
// Within a group the bits switch on in the interleaved fill order, so
// each step adds delay at a stage far away from the previous one
module trim_encoder (
    input  dpll_pkg::trim_level_t level,
    output dpll_pkg::trim_code_t  trim
);
    import dpll_pkg::*;

    // The two halves of the code, built separately
    logic [TRIM_GROUP_BITS-1:0] first_group;
    logic [TRIM_GROUP_BITS-1:0] second_group;

    always_comb begin
        first_group  = '0;
        second_group = '0;

        // Step i of the fill order belongs to level i + 1 in the first
        // group and to level i + 14 in the second group.
        // A bit is on once the level has passed its step, which makes
        // level 0 all zeros and every level from 26 up all ones
        for (int i = 0; i < TRIM_GROUP_BITS; i++) begin
            first_group[TRIM_FILL_ORDER[i]] =
                (level > trim_level_t'(i));
            second_group[TRIM_FILL_ORDER[i]] =
                (level > trim_level_t'(i + TRIM_GROUP_BITS));
        end
    end

    // The second group sits in the upper half of the code
    assign trim = {second_group, first_group};

endmodule

// File: src/dpll_controller.sv
`timescale 1ns/1ps

// Frequency-locked loop controller for a trimmable ring oscillator.
// The local clock comes from the oscillator being trimmed and osc is a
// slow free-running reference. div gives the wanted number of clock
// cycles per osc period. The loop slows the ring when a period holds
// too many cycles and speeds it up when it holds too few
module dpll_controller #(
    parameter int FRAC_BITS = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 osc,
    input  dpll_pkg::count_t     div,
    output dpll_pkg::trim_code_t trim
);
    import dpll_pkg::*;

    // Compare strobe and period sum from the measurement
    period_meas_t meas;

    // Integer trim level from the accumulator
    trim_level_t level;

    // Phase counting and warm-up on the reference input
    period_measure u_period_measure (
        .clock (clock),
        .reset (reset),
        .osc   (osc),
        .meas  (meas)
    );

    // Error integration, FRAC_BITS sets the loop gain
    trim_accumulator #(
        .FRAC_BITS (FRAC_BITS)
    ) u_trim_accumulator (
        .clock (clock),
        .reset (reset),
        .meas  (meas),
        .div   (div),
        .level (level)
    );

    // Level to thermometer code, no register on the way out
    trim_encoder u_trim_encoder (
        .level (level),
        .trim  (trim)
    );

endmodule

// File: dv/dpll_ref_model.svh
`ifndef DPLL_REF_MODEL_SVH
`define DPLL_REF_MODEL_SVH

// Reference model of the loop, kept at the level of whole osc phases.
// It needs FRAC_BITS and the dpll_pkg import from the including module

// Edges seen since reset, the 7-bit trim value and the last phase length
int model_edges;
int model_trim;
int model_prev_len;

// Phase counts stop at 31 in hardware
function automatic int sat_count(input int len);
    return (len > 31) ? 31 : len;
endfunction

function automatic void model_reset();
    model_edges    = 0;
    model_trim     = 0;
    model_prev_len = 0;
endfunction

// One osc toggle after a phase of len cycles, compared against target
function automatic void model_toggle(input int len, input int target);
    int sum;
    model_edges++;
    sum = sat_count(len) + sat_count(model_prev_len);
    // The first three edges only fill the measurement
    if (model_edges >= 4) begin
        if (sum > target && model_trim < MODEL_TRIM_MAX) begin
            model_trim++;
        end else if (sum < target && model_trim > 0) begin
            model_trim--;
        end
    end
    model_prev_len = len;
endfunction

// Number of bits on in each group, then placed by the fill order
function automatic trim_code_t model_code();
    trim_code_t code;
    int level;
    int first_on;
    int second_on;
    code      = '0;
    level     = model_trim >> FRAC_BITS;
    first_on  = (level > TRIM_GROUP_BITS) ? TRIM_GROUP_BITS : level;
    second_on = level - TRIM_GROUP_BITS;
    if (second_on < 0) begin
        second_on = 0;
    end else if (second_on > TRIM_GROUP_BITS) begin
        second_on = TRIM_GROUP_BITS;
    end
    for (int i = 0; i < first_on; i++) begin
        code[TRIM_FILL_ORDER[i]] = 1'b1;
    end
    for (int i = 0; i < second_on; i++) begin
        code[TRIM_GROUP_BITS + TRIM_FILL_ORDER[i]] = 1'b1;
    end
    return code;
endfunction

`endif

// File: dv/dpll_tb.sv
`timescale 1ns/1ps

module dpll_tb;
    import dpll_pkg::*;

    localparam int FRAC_BITS      = 2;
    localparam int MODEL_TRIM_MAX = (32 << FRAC_BITS) - 1;
    // Worst case of all planned phases, random ones taken at 40 cycles
    localparam int PLANNED_CYCLES = 4 + 5*6 + 135*8 + 135*4 + 3*40 + 31 + 18*16
                                    + 200*40 + 8;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    logic       clock = 1'b0;
    logic       reset = 1'b1;
    logic       osc   = 1'b0;
    count_t     div   = '0;
    trim_code_t trim;

    int seed = 32'hbc92;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    `include "dpll_ref_model.svh"

    dpll_controller #(.FRAC_BITS(FRAC_BITS)) UUT (
        .clock (clock),
        .reset (reset),
        .osc   (osc),
        .div   (div),
        .trim  (trim)
    );

    always #50 clock = ~clock;

    // Guards against a stuck run
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run took more clock cycles than all phases together");
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_trim();
        trim_code_t expected;
        expected = model_code();
        assert (trim === expected) else begin
            $display("error: trim expected %h actual %h", expected, trim);
            errors++;
        end
    endtask

    // Waits out one phase, checks the settled code, then toggles osc
    task automatic run_phase(input int len, input count_t new_div);
        repeat (len) @(negedge clock);
        check_trim();
        div = new_div;
        osc = ~osc;
        model_toggle(len, int'(new_div));
    endtask

    task automatic expect_code(input trim_code_t expected);
        assert (trim === expected) else begin
            $display("error: trim expected %h actual %h", expected, trim);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    initial begin
        int start;
        int len;
        trim_code_t held;
        count_t rand_div;

        // Reset holds trim at zero so the ring can start
        start = errors;
        model_reset();
        @(negedge clock);
        expect_code('0);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        expect_code('0);
        report_test("reset", start);

        // Sum of 12 against div 0 steps on every edge once warm
        start = errors;
        for (int i = 0; i < 3; i++) begin
            run_phase(6, count_t'(0));
            expect_code('0);
        end
        // The fifth phase sees the step of the fourth edge.
        // Steps on the first three edges would already reach level 1 there
        run_phase(6, count_t'(0));
        run_phase(6, count_t'(0));
        report_test("warm-up", start);

        // Clock too fast, trim climbs to the top and stays
        start = errors;
        for (int i = 0; i < 135; i++) begin
            run_phase(8, count_t'(2));
        end
        expect_code('1);
        report_test("too fast with saturation", start);

        // Clock too slow, trim falls back to zero and stays
        start = errors;
        for (int i = 0; i < 135; i++) begin
            run_phase(4, count_t'(31));
        end
        expect_code('0);
        report_test("too slow with saturation", start);

        // Long phases count as 31, then 15 plus 16 matches div exactly
        start = errors;
        for (int i = 0; i < 3; i++) begin
            run_phase(40, count_t'(31));
        end
        run_phase(15, count_t'(31));
        run_phase(16, count_t'(31));
        // Sums of 35, 62, 62 and 46 step the trim value from 0 up to 4.
        // That is level 1, only the first bit of the fill order is on
        held = '0;
        held[TRIM_FILL_ORDER[0]] = 1'b1;
        for (int i = 0; i < 18; i++) begin
            run_phase((i % 2 == 0) ? 15 : 16, count_t'(31));
            assert (trim === held) else begin
                $display("error: trim expected %h actual %h while locked", held, trim);
                errors++;
            end
        end
        report_test("count saturation and lock", start);

        // Random phase lengths, a new div every 20 phases
        start = errors;
        for (int i = 0; i < 200; i++) begin
            len = 4 + ($unsigned($random(seed)) % 37);
            if (i % 20 == 0) begin
                rand_div = count_t'($random(seed));
            end
            run_phase(len, rand_div);
        end
        repeat (8) @(negedge clock);
        check_trim();
        report_test("random run", start);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+dv
src/dpll_pkg.sv
src/period_measure.sv
src/trim_accumulator.sv
src/trim_encoder.sv
src/dpll_controller.sv
dv/dpll_tb.sv
